/* wb_periph_top.f */
+incdir+logic
logic/wb_periph_pkg.sv
logic/wb_addr_decoder.sv
logic/wb_ram.sv
logic/gpio_port.sv
logic/wb_resp_mux.sv
logic/wb_periph_top.sv
test/wb_periph_tb.sv

/* Makefile */
TOP             ?= wb_periph_tb
FILELIST        ?= wb_periph_top.f
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_MSG        := All checks passed

.PHONY: build run clean

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/wb_periph_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "wb_periph_config.svh"

module wb_periph_tb
	import wb_periph_pkg::*;
();
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int IDX_W = $clog2(`RAM_WORDS);
	localparam int N_RAND = 48;
	localparam int N_GPIO = 8;
	localparam int N_ERR = 6;
	localparam int NUM_TRANS = `RAM_WORDS + 3 * N_RAND + 7 * N_GPIO + 3 * N_ERR;
	localparam int LAT_LIMIT = 16;

	// one finished bus transaction with its request and observed response
	typedef struct packed {
		logic        we;
		wb_addr_u    adr;
		logic [31:0] wdat;
		logic [3:0]  sel;
		logic [31:0] pins;
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		int          lat;
		logic [31:0] gpo;
	} txn_t;

	logic                   clk;
	logic                   arst_n_i;
	logic                   wb_cyc_i;
	logic                   wb_stb_i;
	logic                   wb_we_i;
	logic [31:0]            wb_adr_i;
	logic [31:0]            wb_dat_i;
	logic [3:0]             wb_sel_i;
	logic [`GPIO_WIDTH-1:0] gpio_i;
	wire [31:0]             wb_dat_o;
	wire                    wb_ack_o;
	wire                    wb_err_o;
	wire                    wb_stall_o;
	wire [`GPIO_WIDTH-1:0]  gpio_o;

	logic [31:0] ram_model [`RAM_WORDS];
	logic [31:0] out_model = '0;
	logic [31:0] dir_model = '0;
	logic [31:0] lcg_state = 32'd98;
	txn_t        txn_q [$];
	event        resp_ev;
	int          data_errs = 0;
	int          kind_errs = 0;
	int          lat_errs = 0;
	int          proto_errs = 0;

	wb_periph_top wb_periph_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] apply_byte_select(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	// returns the expected read data and error flag of one request and applies writes
	// to the shadow state
	function automatic void wb_model_access(input txn_t t, output logic [31:0] exp_dat,
		output logic exp_err);
		logic [31:0]      word_idx;
		logic [IDX_W-1:0] idx;
		word_idx = {10'd0, t.adr.fields.offset[23:2]};
		idx = word_idx[IDX_W-1:0];
		exp_dat = '0;
		exp_err = 1'b0;
		if (t.adr.fields.region == RGN_RAM && word_idx < `RAM_WORDS) begin
			exp_dat = ram_model[idx];
			if (t.we) begin
				ram_model[idx] = apply_byte_select(ram_model[idx], t.wdat, t.sel);
			end
		end else if (t.adr.fields.region == RGN_GPIO && t.adr.fields.offset < `GPIO_WINDOW) begin
			case (t.adr.fields.offset[5:2])
				4'd0: begin
					exp_dat = out_model;
					if (t.we) begin
						out_model = apply_byte_select(out_model, t.wdat, t.sel);
					end
				end
				4'd1: begin
					exp_dat = dir_model;
					if (t.we) begin
						dir_model = apply_byte_select(dir_model, t.wdat, t.sel);
					end
				end
				4'd2: exp_dat = t.pins;
				default: exp_dat = '0;
			endcase
		end else begin
			exp_err = 1'b1;
		end
	endfunction

	task automatic check_data(input string what, input wb_addr_u adr, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			data_errs++;
			$display("error at %0t ns: %s for %h is %h, expected %h", $time, what, adr.word,
				got, exp);
		end
	endtask

	task automatic check_kind(input wb_addr_u adr, input logic ack, input logic err,
		input logic exp_err);
		if (ack !== !exp_err || err !== exp_err) begin
			kind_errs++;
			$display("error at %0t ns: response for %h was ack %b err %b, expected err %b",
				$time, adr.word, ack, err, exp_err);
		end
	endtask

	task automatic check_latency(input wb_addr_u adr, input int got, input int exp);
		if (got != exp) begin
			lat_errs++;
			$display("error at %0t ns: response for %h came after %0d cycles, expected %0d",
				$time, adr.word, got, exp);
		end
	endtask

	// one single read or write that starts and ends on a falling edge
	task automatic bus_access(input logic we, input wb_addr_u adr, input logic [31:0] dat,
		input logic [3:0] sel);
		txn_t t;
		t = '0;
		t.we = we;
		t.adr = adr;
		t.wdat = dat;
		t.sel = sel;
		t.pins = 32'(gpio_i);
		while (wb_stall_o) begin
			@(negedge clk);
		end
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr.word;
		wb_dat_i = dat;
		wb_sel_i = sel;
		@(posedge clk);
		while (!(t.ack || t.err) && t.lat < LAT_LIMIT) begin
			@(negedge clk);
			if (!wb_stall_o) begin
				proto_errs++;
				$display("stall went low while the request to %h was in flight", adr.word);
			end
			t.ack = wb_ack_o;
			t.err = wb_err_o;
			// a response registered n rising edges after acceptance shows up here with lat n
			if (!(t.ack || t.err)) begin
				t.lat++;
			end
		end
		if (!(t.ack || t.err)) begin
			proto_errs++;
			$display("no response to the request at %h within %0d cycles", adr.word, LAT_LIMIT);
		end
		t.rdat = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		while (wb_stall_o) begin
			@(negedge clk);
			if (wb_ack_o || wb_err_o) begin
				proto_errs++;
				$display("a second response came for the request at %h", adr.word);
			end
		end
		t.gpo = 32'(gpio_o);
		txn_q.push_back(t);
		-> resp_ev;
	endtask

	// an unmapped access must fail and leave the location its low bits alias untouched
	task automatic probe_unmapped(input logic [31:0] bad);
		wb_addr_u a;
		wb_addr_u alias_a;
		a.word = bad;
		alias_a.word = {`REGION_RAM, 24'({a.fields.offset[IDX_W+1:2], 2'b00})};
		if (a.fields.region == RGN_GPIO) begin
			alias_a.word = {`REGION_GPIO, 24'(a.fields.offset[5:0])};
		end
		bus_access(1'b1, a, rand32(), 4'hf);
		bus_access(1'b0, a, '0, 4'hf);
		bus_access(1'b0, alias_a, '0, 4'hf);
	endtask

	initial begin
		txn_t        t;
		logic [31:0] exp_dat;
		logic        exp_err;
		forever begin
			@(resp_ev);
			while (txn_q.size() > 0) begin
				t = txn_q.pop_front();
				wb_model_access(t, exp_dat, exp_err);
				check_kind(t.adr, t.ack, t.err, exp_err);
				check_latency(t.adr, t.lat, exp_err ? 2 : 3);
				if (!t.we && !exp_err) begin
					check_data("read data", t.adr, t.rdat, exp_dat);
				end
				if (t.we && t.adr.fields.region == RGN_GPIO) begin
					check_data("gpio_o", t.adr, t.gpo, out_model & dir_model);
				end
			end
		end
	end

	initial begin
		wb_addr_u    a;
		logic [31:0] r;
		arst_n_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		gpio_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);
		a.word = {`REGION_GPIO, 24'd0};
		check_data("gpio_o after reset", a, 32'(gpio_o), '0);
		if (wb_ack_o !== 1'b0 || wb_err_o !== 1'b0 || wb_stall_o !== 1'b0) begin
			proto_errs++;
			$display("error at %0t ns: ack %b err %b stall %b after reset, expected all low",
				$time, wb_ack_o, wb_err_o, wb_stall_o);
		end
		// fill every word so that later partial writes merge with known bytes
		for (int i = 0; i < `RAM_WORDS; i++) begin
			a.word = {`REGION_RAM, 24'({i[IDX_W-1:0], 2'b00})};
			bus_access(1'b1, a, a.word * 32'h9E37_79B1 ^ 32'h5A5A_5A5A, 4'hf);
		end
		for (int n = 0; n < N_RAND; n++) begin
			r = rand32();
			a.word = {`REGION_RAM, 24'({r[IDX_W+15:16], 2'b00})};
			bus_access(1'b1, a, rand32(), r[31:28]);
			bus_access(1'b0, a, '0, 4'hf);
			r = rand32();
			a.word = {`REGION_RAM, 24'({r[IDX_W+15:16], 2'b00})};
			bus_access(1'b0, a, '0, 4'hf);
		end
		for (int n = 0; n < N_GPIO; n++) begin
			r = rand32();
			bus_access(1'b1, {`REGION_GPIO, 24'd0}, rand32(), r[31:28]);
			bus_access(1'b1, {`REGION_GPIO, 24'd4}, rand32(), r[27:24]);
			bus_access(1'b0, {`REGION_GPIO, 24'd0}, '0, 4'hf);
			bus_access(1'b0, {`REGION_GPIO, 24'd4}, '0, 4'hf);
			bus_access(1'b1, {`REGION_GPIO, 24'd8}, rand32(), 4'hf);
			gpio_i = rand32();
			repeat (4) @(negedge clk);
			bus_access(1'b0, {`REGION_GPIO, 24'd8}, '0, 4'hf);
			bus_access(1'b0, {`REGION_GPIO, 24'(6'd12 + {r[18:16], 2'b00})}, '0, 4'hf);
		end
		probe_unmapped(32'h0000_0400);
		probe_unmapped(32'h00FF_FFFC);
		probe_unmapped(32'h0200_0040);
		probe_unmapped(32'h0200_0104);
		probe_unmapped(32'h0100_0010);
		probe_unmapped(32'hFF00_0008);
		@(negedge clk);
		$display("mismatch counts: data %0d, response kind %0d, latency %0d, protocol %0d",
			data_errs, kind_errs, lat_errs, proto_errs);
		if (data_errs + kind_errs + lat_errs + proto_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#((NUM_TRANS * 40 + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the bus transactions did not finish in the expected time");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/wb_periph_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "wb_periph_config.svh"

module wb_periph_top
	import wb_periph_pkg::*;
(
	input  wire                    clk,
	input  wire                    arst_n_i,
	input  wire                    wb_cyc_i,
	input  wire                    wb_stb_i,
	input  wire                    wb_we_i,
	input  wire [31:0]             wb_adr_i,
	input  wire [31:0]             wb_dat_i,
	input  wire [3:0]              wb_sel_i,
	output wire [31:0]             wb_dat_o,
	output wire                    wb_ack_o,
	output wire                    wb_err_o,
	output wire                    wb_stall_o,
	input  wire [`GPIO_WIDTH-1:0]  gpio_i,
	output wire [`GPIO_WIDTH-1:0]  gpio_o
);
	wire            ram_stb;
	wire            gpio_stb;
	wire            req_we;
	wb_addr_u       req_adr;
	wire [31:0]     req_dat;
	wire [3:0]      req_sel;
	wb_slave_e      req_src;
	wire            ram_ack;
	wire [31:0]     ram_dat;
	wire            gpio_ack;
	wire [31:0]     gpio_dat;
	wire            done;

	wb_addr_decoder decoder (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_sel_i   (wb_sel_i),
		.done_i     (done),
		.ram_stb_o  (ram_stb),
		.gpio_stb_o (gpio_stb),
		.req_we_o   (req_we),
		.req_adr_o  (req_adr),
		.req_dat_o  (req_dat),
		.req_sel_o  (req_sel),
		.req_src_o  (req_src),
		.busy_o     (wb_stall_o)
	);

	wb_ram #(
		.WORD_COUNT (`RAM_WORDS)
	) ram (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.stb_i    (ram_stb),
		.we_i     (req_we),
		.adr_i    (req_adr),
		.dat_i    (req_dat),
		.sel_i    (req_sel),
		.dat_o    (ram_dat),
		.ack_o    (ram_ack)
	);

	gpio_port gpioa (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.stb_i    (gpio_stb),
		.we_i     (req_we),
		.adr_i    (req_adr),
		.dat_i    (req_dat),
		.sel_i    (req_sel),
		.gpio_i   (gpio_i),
		.dat_o    (gpio_dat),
		.ack_o    (gpio_ack),
		.gpio_o   (gpio_o)
	);

	wb_resp_mux resp (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.req_src_i  (req_src),
		.ram_ack_i  (ram_ack),
		.ram_dat_i  (ram_dat),
		.gpio_ack_i (gpio_ack),
		.gpio_dat_i (gpio_dat),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.wb_err_o   (wb_err_o),
		.done_o     (done)
	);

endmodule

`default_nettype wire

/* logic/wb_resp_mux.sv */
`default_nettype none
`timescale 1ns/1ns

module wb_resp_mux
	import wb_periph_pkg::*;
(
	input  wire              clk,
	input  wire              arst_n_i,
	input  wire wb_slave_e   req_src_i,
	input  wire              ram_ack_i,
	input  wire [31:0]       ram_dat_i,
	input  wire              gpio_ack_i,
	input  wire [31:0]       gpio_dat_i,
	output logic [31:0]      wb_dat_o,
	output logic             wb_ack_o,
	output logic             wb_err_o,
	output logic             done_o
);
	logic [31:0] dat_q;
	logic        ack_q;
	logic        err_q;
	logic        ram_hit;
	logic        gpio_hit;

	// only the slave that owns the request in flight may answer
	assign ram_hit  = ram_ack_i && (req_src_i == SRC_RAM);
	assign gpio_hit = gpio_ack_i && (req_src_i == SRC_GPIO);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= ram_hit || gpio_hit;
			err_q <= (req_src_i == SRC_ERR);
		end
	end

	always_ff @(posedge clk) begin
		if (ram_hit) begin
			dat_q <= ram_dat_i;
		end else if (gpio_hit) begin
			dat_q <= gpio_dat_i;
		end
	end

	assign wb_dat_o = dat_q;
	assign wb_ack_o = ack_q;
	assign wb_err_o = err_q;
	assign done_o   = ack_q || err_q;

	a_ack_xor_err: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(ack_q && err_q));

	// a slave answers only for a request the decoder routed to it
	a_ack_owned: assert property (@(posedge clk) disable iff (!arst_n_i)
		(ram_ack_i |-> req_src_i == SRC_RAM) and (gpio_ack_i |-> req_src_i == SRC_GPIO));

endmodule

`default_nettype wire

/* logic/gpio_port.sv */
`default_nettype none
`timescale 1ns/1ns

`include "wb_periph_config.svh"

module gpio_port
	import wb_periph_pkg::*;
(
	input  wire                    clk,
	input  wire                    arst_n_i,
	input  wire                    stb_i,
	input  wire                    we_i,
	input  wire wb_addr_u          adr_i,
	input  wire [31:0]             dat_i,
	input  wire [3:0]              sel_i,
	input  wire [`GPIO_WIDTH-1:0]  gpio_i,
	output logic [31:0]            dat_o,
	output logic                   ack_o,
	output logic [`GPIO_WIDTH-1:0] gpio_o
);
	localparam logic [3:0] REG_OUT = 4'd0;
	localparam logic [3:0] REG_DIR = 4'd1;
	localparam logic [3:0] REG_IN  = 4'd2;

	logic [31:0]            out_q;
	logic [31:0]            dir_q;
	logic [31:0]            dat_q;
	logic [`GPIO_WIDTH-1:0] sync1_q;
	logic [`GPIO_WIDTH-1:0] sync2_q;
	logic                   ack_q;
	logic [3:0]             reg_sel;

	assign reg_sel = adr_i.fields.offset[5:2];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_q   <= '0;
			dir_q   <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
			ack_q   <= 1'b0;
		end else begin
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
			ack_q   <= stb_i;
			// the input register is read only
			if (stb_i && we_i) begin
				case (reg_sel)
					REG_OUT: out_q <= byte_merge(out_q, dat_i, sel_i);
					REG_DIR: dir_q <= byte_merge(dir_q, dat_i, sel_i);
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stb_i) begin
			case (reg_sel)
				REG_OUT: dat_q <= out_q;
				REG_DIR: dat_q <= dir_q;
				REG_IN:  dat_q <= 32'(sync2_q);
				default: dat_q <= '0;
			endcase
		end
	end

	assign dat_o  = dat_q;
	assign ack_o  = ack_q;
	// a pin drives only when its direction bit is set
	assign gpio_o = out_q[`GPIO_WIDTH-1:0] & dir_q[`GPIO_WIDTH-1:0];

	a_in_window: assert property (@(posedge clk) disable iff (!arst_n_i)
		stb_i |-> (adr_i.fields.offset < `GPIO_WINDOW));

endmodule

`default_nettype wire

/* logic/wb_ram.sv */
`default_nettype none
`timescale 1ns/1ns

`include "wb_periph_config.svh"

module wb_ram
	import wb_periph_pkg::*;
#(
	parameter int WORD_COUNT = `RAM_WORDS
) (
	input  wire              clk,
	input  wire              arst_n_i,
	input  wire              stb_i,
	input  wire              we_i,
	input  wire wb_addr_u    adr_i,
	input  wire [31:0]       dat_i,
	input  wire [3:0]        sel_i,
	output logic [31:0]      dat_o,
	output logic             ack_o
);
	localparam int IDX_W = $clog2(WORD_COUNT);

	logic [31:0]      mem [WORD_COUNT];
	logic [IDX_W-1:0] idx;
	logic [31:0]      dat_q;
	logic             ack_q;

	// word index within the RAM region
	assign idx = adr_i.fields.offset[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (stb_i) begin
			if (we_i) begin
				mem[idx] <= byte_merge(mem[idx], dat_i, sel_i);
			end
			dat_q <= mem[idx];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= stb_i;
		end
	end

	assign dat_o = dat_q;
	assign ack_o = ack_q;

	// the decoder is expected to turn out-of-range indexes into errors
	a_idx_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		stb_i |-> (adr_i.fields.offset[23:2] < WORD_COUNT));

endmodule

`default_nettype wire

/* logic/wb_addr_decoder.sv */
`default_nettype none
`timescale 1ns/1ns

`include "wb_periph_config.svh"

module wb_addr_decoder
	import wb_periph_pkg::*;
(
	input  wire              clk,
	input  wire              arst_n_i,
	input  wire              wb_cyc_i,
	input  wire              wb_stb_i,
	input  wire              wb_we_i,
	input  wire wb_addr_u    wb_adr_i,
	input  wire [31:0]       wb_dat_i,
	input  wire [3:0]        wb_sel_i,
	input  wire              done_i,
	output logic             ram_stb_o,
	output logic             gpio_stb_o,
	output logic             req_we_o,
	output wb_addr_u         req_adr_o,
	output logic [31:0]      req_dat_o,
	output logic [3:0]       req_sel_o,
	output wb_slave_e        req_src_o,
	output logic             busy_o
);
	wb_addr_u    adr_q;
	logic        we_q;
	logic [31:0] dat_q;
	logic [3:0]  sel_q;
	logic        busy_q;
	logic        issue_q;
	logic        done_q;
	logic        ram_stb_q;
	logic        gpio_stb_q;
	wb_slave_e   src_q;
	logic        accept;
	logic        hit_ram;
	logic        hit_gpio;

	assign accept = wb_cyc_i && wb_stb_i && !busy_q;

	// classification works on the latched address, one cycle after acceptance
	assign hit_ram = (adr_q.fields.region == RGN_RAM) &&
		(adr_q.fields.offset[23:2] < `RAM_WORDS);
	assign hit_gpio = (adr_q.fields.region == RGN_GPIO) &&
		(adr_q.fields.offset < `GPIO_WINDOW);

	always_ff @(posedge clk) begin
		if (accept) begin
			adr_q <= wb_adr_i;
			we_q  <= wb_we_i;
			dat_q <= wb_dat_i;
			sel_q <= wb_sel_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q     <= 1'b0;
			issue_q    <= 1'b0;
			done_q     <= 1'b0;
			ram_stb_q  <= 1'b0;
			gpio_stb_q <= 1'b0;
			src_q      <= SRC_NONE;
		end else begin
			done_q     <= done_i;
			issue_q    <= accept;
			ram_stb_q  <= issue_q && hit_ram;
			gpio_stb_q <= issue_q && hit_gpio;
			// the port stays busy one extra cycle after the response has gone
			if (accept) begin
				busy_q <= 1'b1;
			end else if (done_q) begin
				busy_q <= 1'b0;
			end
			if (issue_q) begin
				if (hit_ram) begin
					src_q <= SRC_RAM;
				end else if (hit_gpio) begin
					src_q <= SRC_GPIO;
				end else begin
					src_q <= SRC_ERR;
				end
			end else if (done_i || src_q == SRC_ERR) begin
				// an error source is shown for one cycle only
				src_q <= SRC_NONE;
			end
		end
	end

	assign ram_stb_o  = ram_stb_q;
	assign gpio_stb_o = gpio_stb_q;
	assign req_we_o   = we_q;
	assign req_adr_o  = adr_q;
	assign req_dat_o  = dat_q;
	assign req_sel_o  = sel_q;
	assign req_src_o  = src_q;
	assign busy_o     = busy_q;

	a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(ram_stb_q && gpio_stb_q));

	// even an error keeps the port busy for four cycles after acceptance
	a_no_reaccept: assert property (@(posedge clk) disable iff (!arst_n_i)
		accept |=> !accept ##1 !accept ##1 !accept ##1 !accept);

endmodule

`default_nettype wire

/* logic/wb_periph_pkg.sv */
`default_nettype none

`include "wb_periph_config.svh"

package wb_periph_pkg;

	// mapped regions, selected by the top address byte
	typedef enum logic [7:0] {
		RGN_RAM  = `REGION_RAM,
		RGN_GPIO = `REGION_GPIO
	} wb_region_e;

	// which block answers the request in flight
	typedef enum logic [1:0] {
		SRC_NONE = 2'd0,
		SRC_RAM  = 2'd1,
		SRC_GPIO = 2'd2,
		SRC_ERR  = 2'd3
	} wb_slave_e;

	typedef struct packed {
		logic [7:0]  region;
		logic [23:0] offset;
	} wb_addr_fields_t;

	// the bus address, seen either flat or split into region and offset
	typedef union packed {
		logic [31:0]     word;
		wb_addr_fields_t fields;
	} wb_addr_u;

	// replaces the bytes of old_word whose select bit is set
	function automatic logic [31:0] byte_merge(
		input logic [31:0] old_word,
		input logic [31:0] new_word,
		input logic [3:0]  sel
	);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return res;
	endfunction

endpackage

`default_nettype wire

/* logic/wb_periph_config.svh */
`ifndef WB_PERIPH_CONFIG_SVH
`define WB_PERIPH_CONFIG_SVH

// RAM depth in 32-bit words
`define RAM_WORDS 'h100

// region codes live in the top byte of the address
`define REGION_RAM 8'h00
`define REGION_GPIO 8'h02

// byte span of the GPIO block inside its region
`define GPIO_WINDOW 64

`define GPIO_WIDTH 32

`endif
